// ==== complex_pkg.sv ====
// Shared widths, accelerator region map and bus payload types, referenced by scoped name
package complex_pkg;

  // Bus geometry
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned strb_width = data_width / 8;

  // Interrupt vector seen by the core
  localparam int unsigned num_irqs     = 32;
  localparam int unsigned irq_id_width = $clog2(num_irqs);

  // Accelerator event lines and where they land in the vector
  localparam int unsigned num_evts    = 2;
  localparam int unsigned evt_irq_lsb = 3;

  // Accelerator configuration region
  localparam logic [addr_width-1:0] accel_region_start = 32'h0010_0000;
  localparam logic [addr_width-1:0] accel_region_size  = 32'h0000_0400;

  // Instruction fetch carries only an address
  typedef logic [addr_width-1:0] inst_req_t;

  // Data access payload
  typedef struct packed {
    logic                  we;
    logic [strb_width-1:0] be;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } data_req_t;

endpackage

// ==== bus_cut.sv ====
// Register slice for a req/gnt/rvalid bus, cutting both the request and the response path
`timescale 1ns/1ps

module bus_cut #(
  parameter type payload_t = logic
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // Upstream side, towards the requester
  input  logic                               up_req_i,
  input  payload_t                           up_payload_i,
  output logic                               up_gnt_o,
  output logic                               up_rvalid_o,
  output logic [complex_pkg::data_width-1:0] up_rdata_o,

  // Downstream side, towards the bus
  output logic                               dn_req_o,
  output payload_t                           dn_payload_o,
  input  logic                               dn_gnt_i,
  input  logic                               dn_rvalid_i,
  input  logic [complex_pkg::data_width-1:0] dn_rdata_i
);

  logic                               slot_valid_q;
  payload_t                           slot_payload_q;
  logic                               up_accept;
  logic                               rvalid_q;
  logic [complex_pkg::data_width-1:0] rdata_q;

  // Slot frees up when the held request is taken downstream this cycle
  assign up_gnt_o  = ~slot_valid_q | dn_gnt_i;
  assign up_accept = up_req_i & up_gnt_o;

  assign dn_req_o     = slot_valid_q;
  assign dn_payload_o = slot_payload_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
    end else if (up_accept) begin
      slot_valid_q <= 1'b1;
    end else if (dn_gnt_i) begin
      slot_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (up_accept) begin
      slot_payload_q <= up_payload_i;
    end
  end

  // Response path, one cycle behind the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= dn_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dn_rvalid_i) begin
      rdata_q <= dn_rdata_i;
    end
  end

  assign up_rvalid_o = rvalid_q;
  assign up_rdata_o  = rdata_q;

endmodule

// ==== data_router.sv ====
// Address decoder that steers core data accesses to the accelerator config port or the external bus
`timescale 1ns/1ps

module data_router (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Core side
  input  logic                                 core_req_i,
  input  complex_pkg::data_req_t               core_payload_i,
  output logic                                 core_gnt_o,
  output logic                                 core_rvalid_o,
  output logic [complex_pkg::data_width-1:0]   core_rdata_o,

  // External data path as target 0
  output logic                                 ext_req_o,
  output complex_pkg::data_req_t               ext_payload_o,
  input  logic                                 ext_gnt_i,
  input  logic                                 ext_rvalid_i,
  input  logic [complex_pkg::data_width-1:0]   ext_rdata_i,

  // Accelerator configuration port as target 1
  output logic                                 periph_req_o,
  output logic [complex_pkg::addr_width-1:0]   periph_add_o,
  output logic                                 periph_wen_o,
  output logic [complex_pkg::strb_width-1:0]   periph_be_o,
  output logic [complex_pkg::data_width-1:0]   periph_data_o,
  input  logic                                 periph_gnt_i,
  input  logic                                 periph_r_valid_i,
  input  logic [complex_pkg::data_width-1:0]   periph_r_data_i
);

  logic                               in_region;
  logic                               route_ok;
  logic                               accept;
  logic                               pending_q;
  logic                               target_q;
  logic                               rsp_valid;

  // Region is [start, start + size)
  assign in_region  = (core_payload_i.addr >= complex_pkg::accel_region_start) &&
                      (core_payload_i.addr <  complex_pkg::accel_region_start +
                                              complex_pkg::accel_region_size);

  // New requests only go out while nothing is in flight
  assign route_ok = core_req_i & ~pending_q;

  assign ext_req_o     = route_ok & ~in_region;
  assign ext_payload_o = core_payload_i;

  assign periph_req_o  = route_ok & in_region;
  assign periph_add_o  = core_payload_i.addr;
  assign periph_wen_o  = ~core_payload_i.we;
  assign periph_be_o   = core_payload_i.be;
  assign periph_data_o = core_payload_i.wdata;

  // Grant follows whichever target is addressed
  assign core_gnt_o = ~pending_q & (in_region ? periph_gnt_i : ext_gnt_i);
  assign accept     = core_req_i & core_gnt_o;

  // Response comes from the target recorded at accept time
  assign rsp_valid     = target_q ? periph_r_valid_i : ext_rvalid_i;
  assign core_rvalid_o = pending_q & rsp_valid;
  assign core_rdata_o  = target_q ? periph_r_data_i : ext_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      target_q  <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
      target_q  <= in_region;
    end else if (pending_q && rsp_valid) begin
      pending_q <= 1'b0;
    end
  end

endmodule

// ==== event_irq.sv ====
// Registers fetch enable as a clock enable and maps accelerator events onto the core interrupt lines
`timescale 1ns/1ps

module event_irq (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 fetch_enable_i,
  input  logic [complex_pkg::num_evts-1:0]     evt_i,
  output logic                                 clk_en_o,
  output logic [complex_pkg::num_irqs-1:0]     irq_o,
  output logic [complex_pkg::irq_id_width-1:0] irq_id_o
);

  logic [complex_pkg::num_irqs-1:0]     irq_d;
  logic [complex_pkg::irq_id_width-1:0] irq_id_d;

  // Events sit at evt_irq_lsb and up, all else zero
  always_comb begin
    irq_d = '0;
    irq_d[complex_pkg::evt_irq_lsb +: complex_pkg::num_evts] = evt_i;
  end

  // Highest set line wins, zero when idle
  always_comb begin
    irq_id_d = '0;
    for (int unsigned i = 0; i < complex_pkg::num_irqs; i++) begin
      if (irq_d[i]) begin
        irq_id_d = i[complex_pkg::irq_id_width-1:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clk_en_o <= 1'b0;
      irq_o    <= '0;
      irq_id_o <= '0;
    end else begin
      clk_en_o <= fetch_enable_i;
      irq_o    <= irq_d;
      irq_id_o <= irq_id_d;
    end
  end

endmodule

// ==== redmule_complex.sv ====
// Top level bus plumbing between the core ports, the external buses and the accelerator config port
`timescale 1ns/1ps

module redmule_complex (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 fetch_enable_i,
  input  logic [complex_pkg::num_evts-1:0]     evt_i,

  // Core instruction port
  input  logic                                 core_inst_req_i,
  input  logic [complex_pkg::addr_width-1:0]   core_inst_addr_i,
  output logic                                 core_inst_gnt_o,
  output logic                                 core_inst_rvalid_o,
  output logic [complex_pkg::data_width-1:0]   core_inst_rdata_o,

  // Core data port
  input  logic                                 core_data_req_i,
  input  logic                                 core_data_we_i,
  input  logic [complex_pkg::strb_width-1:0]   core_data_be_i,
  input  logic [complex_pkg::addr_width-1:0]   core_data_addr_i,
  input  logic [complex_pkg::data_width-1:0]   core_data_wdata_i,
  output logic                                 core_data_gnt_o,
  output logic                                 core_data_rvalid_o,
  output logic [complex_pkg::data_width-1:0]   core_data_rdata_o,

  // External instruction bus
  output logic                                 inst_req_o,
  output logic [complex_pkg::addr_width-1:0]   inst_addr_o,
  input  logic                                 inst_gnt_i,
  input  logic                                 inst_rvalid_i,
  input  logic [complex_pkg::data_width-1:0]   inst_rdata_i,

  // External data bus
  output logic                                 data_req_o,
  output logic                                 data_we_o,
  output logic [complex_pkg::strb_width-1:0]   data_be_o,
  output logic [complex_pkg::addr_width-1:0]   data_addr_o,
  output logic [complex_pkg::data_width-1:0]   data_wdata_o,
  input  logic                                 data_gnt_i,
  input  logic                                 data_rvalid_i,
  input  logic [complex_pkg::data_width-1:0]   data_rdata_i,

  // Accelerator configuration port
  output logic                                 periph_req_o,
  output logic [complex_pkg::addr_width-1:0]   periph_add_o,
  output logic                                 periph_wen_o,
  output logic [complex_pkg::strb_width-1:0]   periph_be_o,
  output logic [complex_pkg::data_width-1:0]   periph_data_o,
  input  logic                                 periph_gnt_i,
  input  logic                                 periph_r_valid_i,
  input  logic [complex_pkg::data_width-1:0]   periph_r_data_i,

  // Control
  output logic                                 clk_en_o,
  output logic [complex_pkg::num_irqs-1:0]     irq_o,
  output logic [complex_pkg::irq_id_width-1:0] irq_id_o
);

  complex_pkg::inst_req_t             inst_cut_payload;
  complex_pkg::data_req_t             core_data_payload;
  complex_pkg::data_req_t             ext_payload;
  complex_pkg::data_req_t             data_cut_payload;
  logic                               ext_req;
  logic                               ext_gnt;
  logic                               ext_rvalid;
  logic [complex_pkg::data_width-1:0] ext_rdata;

  // Instruction fetch slice
  bus_cut #(
    .payload_t ( complex_pkg::inst_req_t )
  ) i_inst_cut (
    .clk_i        ( clk_i              ),
    .rst_ni       ( rst_ni             ),
    .up_req_i     ( core_inst_req_i    ),
    .up_payload_i ( core_inst_addr_i   ),
    .up_gnt_o     ( core_inst_gnt_o    ),
    .up_rvalid_o  ( core_inst_rvalid_o ),
    .up_rdata_o   ( core_inst_rdata_o  ),
    .dn_req_o     ( inst_req_o         ),
    .dn_payload_o ( inst_cut_payload   ),
    .dn_gnt_i     ( inst_gnt_i         ),
    .dn_rvalid_i  ( inst_rvalid_i      ),
    .dn_rdata_i   ( inst_rdata_i       )
  );

  assign inst_addr_o = inst_cut_payload;

  // Pack the loose core data signals
  assign core_data_payload.we    = core_data_we_i;
  assign core_data_payload.be    = core_data_be_i;
  assign core_data_payload.addr  = core_data_addr_i;
  assign core_data_payload.wdata = core_data_wdata_i;

  data_router i_router (
    .clk_i            ( clk_i              ),
    .rst_ni           ( rst_ni             ),
    .core_req_i       ( core_data_req_i    ),
    .core_payload_i   ( core_data_payload  ),
    .core_gnt_o       ( core_data_gnt_o    ),
    .core_rvalid_o    ( core_data_rvalid_o ),
    .core_rdata_o     ( core_data_rdata_o  ),
    .ext_req_o        ( ext_req            ),
    .ext_payload_o    ( ext_payload        ),
    .ext_gnt_i        ( ext_gnt            ),
    .ext_rvalid_i     ( ext_rvalid         ),
    .ext_rdata_i      ( ext_rdata          ),
    .periph_req_o     ( periph_req_o       ),
    .periph_add_o     ( periph_add_o       ),
    .periph_wen_o     ( periph_wen_o       ),
    .periph_be_o      ( periph_be_o        ),
    .periph_data_o    ( periph_data_o      ),
    .periph_gnt_i     ( periph_gnt_i       ),
    .periph_r_valid_i ( periph_r_valid_i   ),
    .periph_r_data_i  ( periph_r_data_i    )
  );

  // External data slice behind router port 0
  bus_cut #(
    .payload_t ( complex_pkg::data_req_t )
  ) i_data_cut (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .up_req_i     ( ext_req          ),
    .up_payload_i ( ext_payload      ),
    .up_gnt_o     ( ext_gnt          ),
    .up_rvalid_o  ( ext_rvalid       ),
    .up_rdata_o   ( ext_rdata        ),
    .dn_req_o     ( data_req_o       ),
    .dn_payload_o ( data_cut_payload ),
    .dn_gnt_i     ( data_gnt_i       ),
    .dn_rvalid_i  ( data_rvalid_i    ),
    .dn_rdata_i   ( data_rdata_i     )
  );

  assign data_we_o    = data_cut_payload.we;
  assign data_be_o    = data_cut_payload.be;
  assign data_addr_o  = data_cut_payload.addr;
  assign data_wdata_o = data_cut_payload.wdata;

  event_irq i_event_irq (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .evt_i          ( evt_i          ),
    .clk_en_o       ( clk_en_o       ),
    .irq_o          ( irq_o          ),
    .irq_id_o       ( irq_id_o       )
  );

endmodule

// ==== tb_redmule_complex.sv ====
// Testbench for redmule_complex with bus responders, random accesses and assertion checks
`timescale 1ns/1ps

// Simple bus target that grants after 0 to 3 cycles and answers with address XOR key
module bus_responder #(
  parameter logic [31:0] key = 32'h0
) (
  input  logic        clk_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  logic        pend;
  logic [31:0] pend_addr;
  int unsigned wait_cnt;
  logic        gnt_next;

  initial begin
    gnt_o     = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    pend      = 1'b0;
    pend_addr = '0;
    wait_cnt  = 0;
    gnt_next  = 1'b0;
    forever begin
      // Sample the cycle that ends at this edge
      @(posedge clk_i);
      pend = req_i && gnt_o;
      if (pend) begin
        pend_addr = addr_i;
        wait_cnt  = $urandom_range(3);
      end else if (wait_cnt > 0) begin
        wait_cnt--;
      end
      gnt_next = (wait_cnt == 0);
      @(negedge clk_i);
      gnt_o    = gnt_next;
      rvalid_o = pend;
      rdata_o  = pend ? (pend_addr ^ key) : '0;
    end
  end

endmodule

module tb_redmule_complex;

  localparam logic [31:0] inst_key       = 32'hA5A5_0000;
  localparam logic [31:0] data_key       = 32'h5A5A_1111;
  localparam logic [31:0] periph_key     = 32'h0F0F_2222;
  localparam int unsigned timeout_cycles = 50;
  localparam logic [31:0] region_start   = complex_pkg::accel_region_start;
  localparam logic [31:0] region_end     = complex_pkg::accel_region_start +
                                           complex_pkg::accel_region_size;

  logic        clk_i;
  logic        rst_ni;
  logic        fetch_enable_i;
  logic [1:0]  evt_i;
  logic        core_inst_req_i;
  logic [31:0] core_inst_addr_i;
  logic        core_inst_gnt_o;
  logic        core_inst_rvalid_o;
  logic [31:0] core_inst_rdata_o;
  logic        core_data_req_i;
  logic        core_data_we_i;
  logic [3:0]  core_data_be_i;
  logic [31:0] core_data_addr_i;
  logic [31:0] core_data_wdata_i;
  logic        core_data_gnt_o;
  logic        core_data_rvalid_o;
  logic [31:0] core_data_rdata_o;
  logic        inst_req_o;
  logic [31:0] inst_addr_o;
  logic        inst_gnt_i;
  logic        inst_rvalid_i;
  logic [31:0] inst_rdata_i;
  logic        data_req_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;
  logic [31:0] data_rdata_i;
  logic        periph_req_o;
  logic [31:0] periph_add_o;
  logic        periph_wen_o;
  logic [3:0]  periph_be_o;
  logic [31:0] periph_data_o;
  logic        periph_gnt_i;
  logic        periph_r_valid_i;
  logic [31:0] periph_r_data_i;
  logic        clk_en_o;
  logic [31:0] irq_o;
  logic [4:0]  irq_id_o;

  int unsigned error_count;
  int unsigned test_count;
  int unsigned failed_tests;
  int unsigned fetch_count;
  int unsigned inst_rsp_count;

  redmule_complex dut_i (.*);

  bus_responder #(.key(inst_key)) i_inst_rsp (
    .clk_i (clk_i), .req_i (inst_req_o), .addr_i (inst_addr_o),
    .gnt_o (inst_gnt_i), .rvalid_o (inst_rvalid_i), .rdata_o (inst_rdata_i)
  );

  bus_responder #(.key(data_key)) i_data_rsp (
    .clk_i (clk_i), .req_i (data_req_o), .addr_i (data_addr_o),
    .gnt_o (data_gnt_i), .rvalid_o (data_rvalid_i), .rdata_o (data_rdata_i)
  );

  bus_responder #(.key(periph_key)) i_periph_rsp (
    .clk_i (clk_i), .req_i (periph_req_o), .addr_i (periph_add_o),
    .gnt_o (periph_gnt_i), .rvalid_o (periph_r_valid_i), .rdata_o (periph_r_data_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic in_region(input logic [31:0] addr);
    return (addr >= region_start) && (addr < region_end);
  endfunction

  // Outputs that must stay quiet while reset is held
  a_reset_quiet: assert property (@(posedge clk_i) !rst_ni |->
      !(inst_req_o || data_req_o || periph_req_o || core_inst_rvalid_o ||
        core_data_rvalid_o || clk_en_o || (irq_o != 0) || (irq_id_o != 0)))
    else begin
      error_count++;
      $display("An output was active while reset was held");
    end

  a_periph_in_region: assert property (@(posedge clk_i) disable iff (!rst_ni)
      periph_req_o |-> in_region(periph_add_o))
    else begin
      error_count++;
      $display("periph_req_o raised for an address outside the accelerator region");
    end

  a_data_out_of_region: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_o |-> !in_region(data_addr_o))
    else begin
      error_count++;
      $display("data_req_o raised for an address inside the accelerator region");
    end

  // Only one data transaction may be in flight
  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(periph_req_o && data_req_o))
    else begin
      error_count++;
      $display("Peripheral and external data requests were active together");
    end

  always @(posedge clk_i) begin
    if (rst_ni && core_inst_rvalid_o) begin
      inst_rsp_count++;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    a_value: assert (got === exp)
      else begin
        error_count++;
        $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
      end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic end_test(input string name, input int unsigned errors_before);
    test_count++;
    if (error_count != errors_before) begin
      failed_tests++;
      $display("test %s: FAILED", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic wait_data_rvalid();
    int unsigned cnt;
    cnt = 0;
    @(posedge clk_i);
    while (!core_data_rvalid_o && cnt < timeout_cycles) begin
      cnt++;
      @(posedge clk_i);
    end
    if (cnt >= timeout_cycles) abort_run("core_data_rvalid_o");
  endtask

  task automatic wait_data_gnt();
    int unsigned cnt;
    cnt = 0;
    @(posedge clk_i);
    while (!core_data_gnt_o && cnt < timeout_cycles) begin
      cnt++;
      @(posedge clk_i);
    end
    if (cnt >= timeout_cycles) abort_run("core_data_gnt_o");
  endtask

  task automatic do_fetch(input logic [31:0] addr);
    int unsigned cnt;
    @(negedge clk_i);
    core_inst_req_i  = 1'b1;
    core_inst_addr_i = addr;
    cnt = 0;
    @(posedge clk_i);
    while (!core_inst_gnt_o && cnt < timeout_cycles) begin
      cnt++;
      @(posedge clk_i);
    end
    if (cnt >= timeout_cycles) abort_run("core_inst_gnt_o");
    @(negedge clk_i);
    core_inst_req_i = 1'b0;
    check_word("inst_req_o", inst_req_o, 32'd1);
    check_word("inst_addr_o", inst_addr_o, addr);
    cnt = 0;
    @(posedge clk_i);
    while (!core_inst_rvalid_o && cnt < timeout_cycles) begin
      cnt++;
      @(posedge clk_i);
    end
    if (cnt >= timeout_cycles) abort_run("core_inst_rvalid_o");
    check_word("core_inst_rdata_o", core_inst_rdata_o, addr ^ inst_key);
    fetch_count++;
  endtask

  task automatic data_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                             input logic [31:0] wdata);
    logic periph;
    periph = in_region(addr);
    @(negedge clk_i);
    core_data_req_i   = 1'b1;
    core_data_we_i    = we;
    core_data_be_i    = be;
    core_data_addr_i  = addr;
    core_data_wdata_i = wdata;
    wait_data_gnt();
    if (periph) begin
      // Peripheral request is visible in the granted cycle
      check_word("periph_req_o", periph_req_o, 32'd1);
      check_word("periph_add_o", periph_add_o, addr);
      check_word("periph_wen_o", periph_wen_o, {31'd0, ~we});
      check_word("periph_be_o", periph_be_o, be);
      check_word("periph_data_o", periph_data_o, wdata);
    end else begin
      check_word("periph_req_o", periph_req_o, 32'd0);
    end
    @(negedge clk_i);
    core_data_req_i = 1'b0;
    if (periph) begin
      // A misrouted access would now sit in the data slice
      check_word("data_req_o", data_req_o, 32'd0);
    end else begin
      check_word("data_req_o", data_req_o, 32'd1);
      check_word("data_we_o", data_we_o, we);
      check_word("data_be_o", data_be_o, be);
      check_word("data_addr_o", data_addr_o, addr);
      check_word("data_wdata_o", data_wdata_o, wdata);
    end
    wait_data_rvalid();
    if (!we) begin
      check_word("core_data_rdata_o", core_data_rdata_o,
                 addr ^ (periph ? periph_key : data_key));
    end
  endtask

  initial begin
    int unsigned errs;
    int unsigned cnt;
    logic [31:0] addr;
    logic [31:0] addr2;

    void'($urandom(32'h4673_4d9f));
    error_count       = 0;
    test_count        = 0;
    failed_tests      = 0;
    fetch_count       = 0;
    inst_rsp_count    = 0;
    rst_ni            = 1'b0;
    fetch_enable_i    = 1'b0;
    evt_i             = '0;
    core_inst_req_i   = 1'b0;
    core_inst_addr_i  = '0;
    core_data_req_i   = 1'b0;
    core_data_we_i    = 1'b0;
    core_data_be_i    = '0;
    core_data_addr_i  = '0;
    core_data_wdata_i = '0;

    // Test 1 checks reset values and fetch enable
    errs = error_count;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    check_word("inst_req_o", inst_req_o, 32'd0);
    check_word("data_req_o", data_req_o, 32'd0);
    check_word("periph_req_o", periph_req_o, 32'd0);
    check_word("core_inst_rvalid_o", core_inst_rvalid_o, 32'd0);
    check_word("core_data_rvalid_o", core_data_rvalid_o, 32'd0);
    check_word("clk_en_o", clk_en_o, 32'd0);
    check_word("irq_o", irq_o, 32'd0);
    check_word("irq_id_o", irq_id_o, 32'd0);
    @(negedge clk_i);
    fetch_enable_i = 1'b1;
    @(negedge clk_i);
    check_word("clk_en_o", clk_en_o, 32'd1);
    end_test("reset", errs);

    // Test 2 runs instruction fetches
    errs = error_count;
    repeat (8) do_fetch($urandom & 32'hFFFF_FFFC);
    repeat (3) @(posedge clk_i);
    check_word("fetch rvalid count", inst_rsp_count, fetch_count);
    end_test("fetch", errs);

    // Test 3 writes and reads inside the accelerator region and at its edges
    errs = error_count;
    addr = region_start + (($urandom % complex_pkg::accel_region_size) & 32'hFFFF_FFFC);
    data_access(1'b1, $urandom, addr, $urandom);
    data_access(1'b0, 4'hF, addr, '0);
    data_access(1'b0, 4'hF, region_start, '0);
    data_access(1'b0, 4'hF, region_end - 4, '0);
    end_test("accel_region", errs);

    // Test 4 covers external accesses on both sides of the region
    errs = error_count;
    data_access(1'b0, 4'hF, region_start - 4, '0);
    data_access(1'b1, $urandom, region_end, $urandom);
    data_access(1'b0, 4'hF, region_end, '0);
    repeat (4) begin
      addr = ($urandom % region_start) & 32'hFFFF_FFFC;
      data_access($urandom, $urandom, addr, $urandom);
      addr = region_end + (($urandom % 32'h0100_0000) & 32'hFFFF_FFFC);
      data_access($urandom, $urandom, addr, $urandom);
    end
    end_test("external_data", errs);

    // Test 5 holds a register access back while an external read is pending
    errs = error_count;
    addr  = ($urandom % region_start) & 32'hFFFF_FFFC;
    addr2 = region_start + (($urandom % complex_pkg::accel_region_size) & 32'hFFFF_FFFC);
    @(negedge clk_i);
    core_data_req_i  = 1'b1;
    core_data_we_i   = 1'b0;
    core_data_be_i   = 4'hF;
    core_data_addr_i = addr;
    wait_data_gnt();
    @(negedge clk_i);
    core_data_addr_i = addr2;
    cnt = 0;
    @(posedge clk_i);
    while (!core_data_rvalid_o && cnt < timeout_cycles) begin
      check_word("core_data_gnt_o", core_data_gnt_o, 32'd0);
      cnt++;
      @(posedge clk_i);
    end
    if (cnt >= timeout_cycles) abort_run("first pending response");
    check_word("core_data_gnt_o", core_data_gnt_o, 32'd0);
    check_word("core_data_rdata_o", core_data_rdata_o, addr ^ data_key);
    wait_data_gnt();
    @(negedge clk_i);
    core_data_req_i = 1'b0;
    wait_data_rvalid();
    check_word("core_data_rdata_o", core_data_rdata_o, addr2 ^ periph_key);
    end_test("one_in_flight", errs);

    // Test 6 covers the event to interrupt mapping
    errs = error_count;
    for (int e = 0; e < 4; e++) begin
      @(negedge clk_i);
      evt_i = e[1:0];
      @(negedge clk_i);
      check_word("irq_o", irq_o, {27'd0, e[1:0], 3'd0});
      check_word("irq_id_o", irq_id_o, e[1] ? 32'd4 : (e[0] ? 32'd3 : 32'd0));
    end
    end_test("events", errs);

    $display("tests: %0d, failing tests: %0d, errors: %0d", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
complex_pkg.sv
bus_cut.sv
data_router.sv
event_irq.sv
redmule_complex.sv
tb_redmule_complex.sv

// ==== Bender.yml ====
package:
  name: redmule_complex

sources:
  - complex_pkg.sv
  - bus_cut.sv
  - data_router.sv
  - event_irq.sv
  - redmule_complex.sv
  - target: test
    files:
      - tb_redmule_complex.sv
